/* tb.f */
hdl/strip_ctrl_pkg.sv
hdl/strip_if.sv
hdl/req_burst_cnt.sv
hdl/strip_ctrl_fsm.sv
hdl/strip_buffer.sv
hdl/strip_ctrl_top.sv
test/ddr_app_model.sv
test/strip_ctrl_checker.sv
test/strip_ctrl_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module strip_ctrl_tb -f tb.f -o sim_tb

# The simulation may stop with a nonzero status, the log decides
./obj_dir/sim_tb +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
	echo "Simulation failed"
	exit 1
fi
if ! grep -q '\*\* PASS \*\*' sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
echo "Simulation passed"

/* test/strip_ctrl_tb.sv */
`timescale 1ns/1ps

module strip_ctrl_tb import strip_ctrl_pkg::*; ();

	// Room for 20 strips of 64 beats at 12 cycles of 40 ns per beat
	localparam int WATCHDOG_NS = 20 * 64 * 12 * 40;

	logic clk = 1'b0;
	logic reset;
	logic req;
	logic we;
	app_addr_t adr;
	burst_len_t len;
	logic done;
	logic ld_en;
	burst_len_t ld_idx;
	app_data_t ld_data;
	burst_len_t fetch_idx;
	app_data_t fetch_data;
	logic app_en;
	app_cmd_t app_cmd;
	app_addr_t app_addr;
	logic app_rdy;
	logic app_wdf_wren;
	app_data_t app_wdf_data;
	logic app_wdf_end;
	logic app_wdf_rdy;
	app_data_t app_rd_data;
	logic app_rd_data_valid;
	int accepted;
	int returned;
	app_addr_t last_addr;
	int done_cnt = 0;
	int strip_cnt = 0;

	// Expected memory content, one word per beat address
	app_data_t ref_mem [app_addr_t];

	strip_ctrl_top i_dut (.*);

	ddr_app_model i_mem (.*);

	bind strip_ctrl_top strip_ctrl_checker i_checker (
		.clk(clk), .reset(reset), .req(req), .done(done), .app_en(app_en),
		.app_rdy(app_rdy), .app_wdf_wren(app_wdf_wren), .app_wdf_end(app_wdf_end),
		.app_wdf_rdy(app_wdf_rdy), .app_cmd(app_cmd), .app_addr(app_addr),
		.app_wdf_data(app_wdf_data)
	);

	always #20 clk = ~clk;

	// Every done pulse is counted, so a missing or extra one shows up
	always @(posedge clk) begin
		if (done) begin
			done_cnt <= done_cnt + 1;
		end
	end

	task automatic fail_run(input string line);
		$display("%s", line);
		$display("** FAIL **");
		$fatal(1, "Simulation stopped");
	endtask

	function automatic app_addr_t beat_addr(input app_addr_t base, input int beat);
		return base + app_addr_t'(beat) * BEAT_BYTES;
	endfunction

	// ============================================================
	// Strip level stimulus
	// ============================================================

	// Loads the buffer with fresh words, or with the inverse of the expected ones
	task automatic load_buffer(input app_addr_t base, input burst_len_t l, input logic fresh);
		app_data_t word;
		for (int i = 0; i <= int'(l); i++) begin
			if (fresh) begin
				word = {$urandom(), $urandom(), $urandom(), $urandom()};
				ref_mem[beat_addr(base, i)] = word;
			end else begin
				word = ~ref_mem[beat_addr(base, i)];
			end
			@(posedge clk);
			ld_en <= 1'b1;
			ld_idx <= burst_len_t'(i);
			ld_data <= word;
		end
		@(posedge clk);
		ld_en <= 1'b0;
	endtask

	task automatic run_strip(input logic dir, input app_addr_t base, input burst_len_t l);
		int acc0;
		int ret0;
		acc0 = accepted;
		ret0 = returned;
		strip_cnt++;
		@(posedge clk);
		req <= 1'b1;
		we <= dir;
		adr <= base;
		len <= l;
		@(posedge clk);
		req <= 1'b0;
		// The watchdog bounds this wait
		do @(posedge clk); while (!done);
		assert (accepted - acc0 == int'(l) + 1)
			else fail_run($sformatf("Fail %0t accepted_beats expected %0d got %0d",
				$time, int'(l) + 1, accepted - acc0));
		assert (last_addr == beat_addr(base, int'(l)))
			else fail_run($sformatf("Fail %0t app_addr expected %h got %h",
				$time, beat_addr(base, int'(l)), last_addr));
		// A read ends only once every word has come back
		assert (dir || returned - ret0 == int'(l) + 1)
			else fail_run($sformatf("Fail %0t app_rd_data_valid expected %0d got %0d",
				$time, int'(l) + 1, returned - ret0));
		@(posedge clk);
		assert (done_cnt == strip_cnt)
			else fail_run($sformatf("Fail %0t done expected %0d got %0d",
				$time, strip_cnt, done_cnt));
	endtask

	task automatic check_fetch(input app_addr_t base, input burst_len_t l);
		for (int i = 0; i <= int'(l); i++) begin
			@(posedge clk);
			fetch_idx <= burst_len_t'(i);
			@(posedge clk);
			assert (fetch_data == ref_mem[beat_addr(base, i)])
				else fail_run($sformatf("Fail %0t fetch_data expected %h got %h",
					$time, ref_mem[beat_addr(base, i)], fetch_data));
		end
	endtask

	// The buffer is spoiled between the write and the read, so stale words cannot pass
	task automatic write_and_read(input app_addr_t base, input burst_len_t l);
		load_buffer(base, l, 1'b1);
		run_strip(1'b1, base, l);
		load_buffer(base, l, 1'b0);
		run_strip(1'b0, base, l);
		check_fetch(base, l);
	endtask

	// ============================================================
	// Run control
	// ============================================================

	initial begin
		#(WATCHDOG_NS);
		fail_run("Timeout, the strips did not finish in time");
	end

	initial begin
		wait (i_dut.i_checker.failed);
		fail_run("An assertion on the memory port failed");
	end

	initial begin
		logic [31:0] rnd;
		void'($urandom(32'he01f));
		reset <= 1'b1;
		req <= 1'b0;
		we <= 1'b0;
		adr <= '0;
		len <= '0;
		ld_en <= 1'b0;
		ld_idx <= '0;
		ld_data <= '0;
		fetch_idx <= '0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		// Shortest and longest strips first, then random ones
		write_and_read(28'h0000100, 6'd0);
		write_and_read(28'h0004000, 6'd63);
		repeat (8) begin
			rnd = $urandom();
			write_and_read({rnd[23:0], 4'h0}, rnd[29:24]);
		end
		repeat (4) @(posedge clk);
		if (i_dut.i_checker.failed) begin
			fail_run("An assertion on the memory port failed");
		end else begin
			$display("** PASS **");
			$finish;
		end
	end

endmodule

/* test/strip_ctrl_checker.sv */
`timescale 1ns/1ps

// Concurrent assertions on the memory port of the strip controller
module strip_ctrl_checker import strip_ctrl_pkg::*; (
	input logic clk,
	input logic reset,
	input logic req,
	input logic done,
	input logic app_en,
	input logic app_rdy,
	input logic app_wdf_wren,
	input logic app_wdf_end,
	input logic app_wdf_rdy,
	input app_cmd_t app_cmd,
	input app_addr_t app_addr,
	input app_data_t app_wdf_data
);

	// Each flag is raised by the action block of its own assertion
	logic fail_hold = 1'b0;
	logic fail_step = 1'b0;
	logic fail_wdf = 1'b0;
	logic fail_reset = 1'b0;
	logic fail_done = 1'b0;
	logic fail_start = 1'b0;

	// Raised once any assertion of this module has failed
	logic failed;

	// The memory takes the offered beat in this cycle
	logic accept;

	assign accept = app_en && app_rdy && (!app_wdf_wren || app_wdf_rdy);
	assign failed = fail_hold | fail_step | fail_wdf | fail_reset | fail_done | fail_start;

	// ============================================================
	// Command port rules
	// ============================================================

	// A stalled beat keeps its command, address and data word
	hold_a: assert property (@(posedge clk) disable iff (reset)
		app_en && !accept |=> app_en && $stable(app_addr) && $stable(app_cmd)
			&& $stable(app_wdf_wren) && (!app_wdf_wren || $stable(app_wdf_data)))
		else begin
			fail_hold = 1'b1;
			$error("Stalled beat changed before it was accepted");
		end

	// The next beat of a strip sits one beat further up, with the same command
	step_a: assert property (@(posedge clk) disable iff (reset)
		accept |=> !app_en || (app_addr == $past(app_addr) + BEAT_BYTES
			&& $stable(app_cmd)))
		else begin
			fail_step = 1'b1;
			$error("Beat address did not step by one beat");
		end

	// Write data goes only with a write command and every word closes its burst
	wdf_a: assert property (@(posedge clk) disable iff (reset)
		(app_wdf_wren == (app_en && app_cmd == CMD_WRITE))
			&& (app_wdf_end == app_wdf_wren))
		else begin
			fail_wdf = 1'b1;
			$error("Write data strobes do not match the command");
		end

	// ============================================================
	// Reset and strip framing
	// ============================================================

	reset_a: assert property (@(posedge clk)
		reset |=> !app_en && !app_wdf_wren && !done)
		else begin
			fail_reset = 1'b1;
			$error("Outputs not quiet after reset");
		end

	// Done is a single-cycle pulse with no command beside it
	done_a: assert property (@(posedge clk) disable iff (reset)
		done |-> !app_en ##1 !done)
		else begin
			fail_done = 1'b1;
			$error("Done pulse too long or overlapping a command");
		end

	// Issue only ever opens four cycles after a request
	start_a: assert property (@(posedge clk) disable iff (reset)
		$rose(app_en) |-> $past(req, 4))
		else begin
			fail_start = 1'b1;
			$error("Command issue started without a request");
		end

endmodule

/* test/ddr_app_model.sv */
`timescale 1ns/1ps

// Behavioral DDR application port with random stalls and in-order reads
module ddr_app_model import strip_ctrl_pkg::*; (
	input logic clk,
	input logic reset,
	input logic app_en,
	input app_cmd_t app_cmd,
	input app_addr_t app_addr,
	output logic app_rdy,
	input logic app_wdf_wren,
	input app_data_t app_wdf_data,
	output logic app_wdf_rdy,
	output app_data_t app_rd_data,
	output logic app_rd_data_valid,
	output int accepted,
	output int returned,
	output app_addr_t last_addr
);

	// Sparse storage, only touched words exist
	app_data_t mem [app_addr_t];

	// Pending read words in command order, each with its due cycle
	app_data_t rd_data_q [$];
	int rd_due_q [$];

	int cycle = 0;
	logic rdy_q = 1'b0;
	logic wdf_rdy_q = 1'b0;
	logic valid_q = 1'b0;
	app_data_t rd_word_q = '0;
	int accepted_q = 0;
	int returned_q = 0;
	app_addr_t last_addr_q = '0;

	// A command, and for writes its data word, is taken this cycle
	logic take;

	assign take = app_en && app_rdy && (app_cmd != CMD_WRITE || (app_wdf_wren && app_wdf_rdy));

	assign app_rdy = rdy_q;
	assign app_wdf_rdy = wdf_rdy_q;
	assign app_rd_data = rd_word_q;
	assign app_rd_data_valid = valid_q;
	assign accepted = accepted_q;
	assign returned = returned_q;
	assign last_addr = last_addr_q;

	// Content of a word never written, built from the full address
	function automatic app_data_t fill_word(input app_addr_t a);
		return {4{4'h5, a}};
	endfunction

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (reset) begin
			rdy_q <= 1'b0;
			wdf_rdy_q <= 1'b0;
			valid_q <= 1'b0;
			rd_data_q.delete();
			rd_due_q.delete();
		end else begin
			// About one cycle in four stalls on each ready
			rdy_q <= ($urandom % 4) != 0;
			wdf_rdy_q <= ($urandom % 4) != 0;
			if (take) begin
				accepted_q <= accepted_q + 1;
				last_addr_q <= app_addr;
				if (app_cmd == CMD_WRITE) begin
					mem[app_addr] = app_wdf_data;
				end else begin
					rd_data_q.push_back(mem.exists(app_addr) ? mem[app_addr] : fill_word(app_addr));
					// Latency of 2 to 9 cycles
					rd_due_q.push_back(cycle + 2 + int'($urandom % 8));
				end
			end
			// Only the oldest word may leave, which keeps command order
			if (rd_due_q.size() > 0 && rd_due_q[0] <= cycle) begin
				rd_word_q <= rd_data_q.pop_front();
				void'(rd_due_q.pop_front());
				valid_q <= 1'b1;
				returned_q <= returned_q + 1;
			end else begin
				valid_q <= 1'b0;
			end
		end
	end

endmodule

/* hdl/strip_ctrl_top.sv */
`timescale 1ns/1ps

// Strip-transfer controller with plain client and memory ports
module strip_ctrl_top import strip_ctrl_pkg::*; (
	input logic clk,
	input logic reset,
	// Client request
	input logic req,
	input logic we,
	input app_addr_t adr,
	input burst_len_t len,
	output logic done,
	// Client buffer access
	input logic ld_en,
	input burst_len_t ld_idx,
	input app_data_t ld_data,
	input burst_len_t fetch_idx,
	output app_data_t fetch_data,
	// Memory command port
	output logic app_en,
	output app_cmd_t app_cmd,
	output app_addr_t app_addr,
	input logic app_rdy,
	// Memory write data
	output logic app_wdf_wren,
	output app_data_t app_wdf_data,
	output logic app_wdf_end,
	input logic app_wdf_rdy,
	// Memory read data
	input app_data_t app_rd_data,
	input logic app_rd_data_valid
);

	// ============================================================
	// Internal links between the three blocks
	// ============================================================

	strip_if sif ();

	strip_ctrl_fsm u_fsm (
		.clk(clk),
		.reset(reset),
		.sif(sif.ctrl),
		.req(req),
		.we(we),
		.adr(adr),
		.len(len),
		.done(done),
		.app_en(app_en),
		.app_wdf_wren(app_wdf_wren),
		.app_wdf_end(app_wdf_end),
		.app_cmd(app_cmd),
		.app_addr(app_addr),
		.app_rdy(app_rdy),
		.app_wdf_rdy(app_wdf_rdy)
	);

	// Tells the FSM whether beats of the strip remain
	req_burst_cnt u_cnt (
		.clk(clk),
		.sif(sif.cnt)
	);

	strip_buffer u_buf (
		.clk(clk),
		.reset(reset),
		.sif(sif.buff),
		.ld_en(ld_en),
		.ld_idx(ld_idx),
		.ld_data(ld_data),
		.fetch_idx(fetch_idx),
		.fetch_data(fetch_data),
		.app_wdf_data(app_wdf_data),
		.app_rd_data(app_rd_data),
		.app_rd_data_valid(app_rd_data_valid)
	);

endmodule

/* hdl/strip_buffer.sv */
`timescale 1ns/1ps

// Strip storage shared by the client port and the memory data paths
module strip_buffer import strip_ctrl_pkg::*; (
	input logic clk,
	input logic reset,
	strip_if.buff sif,
	input logic ld_en,
	input burst_len_t ld_idx,
	input app_data_t ld_data,
	input burst_len_t fetch_idx,
	output app_data_t fetch_data,
	output app_data_t app_wdf_data,
	input app_data_t app_rd_data,
	input logic app_rd_data_valid
);

	// One word per possible beat of a strip
	app_data_t mem [STRIP_DEPTH];

	// Slot for the next returned read word
	burst_len_t rd_idx;

	// Set once the word for the last index has been stored
	logic rd_done;

	// The read path is active, returns may overlap command issue
	logic rd_phase;

	// A returned word is written into the buffer in this cycle
	logic rd_capture;

	assign rd_phase = (sif.state == READ_DATA0) || (sif.state == READ_DATA1);
	assign rd_capture = rd_phase && app_rd_data_valid && !rd_done;

	// ============================================================
	// Read return tracking
	// ============================================================

	// Words come back in command order, so a plain index is enough
	always_ff @(posedge clk) begin
		if (reset) begin
			rd_idx <= '0;
			rd_done <= 1'b0;
		end else if (sif.state == PRESET2) begin
			rd_idx <= '0;
			rd_done <= 1'b0;
		end else if (rd_capture) begin
			if (rd_idx == sif.burst_len) begin
				rd_done <= 1'b1;
			end else begin
				rd_idx <= rd_idx + 6'd1;
			end
		end
	end

	assign sif.rd_all = rd_done;

	// ============================================================
	// Storage
	// ============================================================

	// Returned words take priority; the client may load only while idle
	always_ff @(posedge clk) begin
		if (rd_capture) begin
			mem[rd_idx] <= app_rd_data;
		end else if (ld_en && sif.state == IDLE) begin
			mem[ld_idx] <= ld_data;
		end
	end

	// The beat being issued picks its write word
	assign app_wdf_data = mem[sif.burst_cnt];

	// Client fetch is a plain asynchronous read
	assign fetch_data = mem[fetch_idx];

endmodule

/* hdl/strip_ctrl_fsm.sv */
`timescale 1ns/1ps

// Strip state machine that drives the memory command port
module strip_ctrl_fsm import strip_ctrl_pkg::*; (
	input logic clk,
	input logic reset,
	strip_if.ctrl sif,
	input logic req,
	input logic we,
	input app_addr_t adr,
	input burst_len_t len,
	output logic done,
	output logic app_en,
	output logic app_wdf_wren,
	output logic app_wdf_end,
	output app_cmd_t app_cmd,
	output app_addr_t app_addr,
	input logic app_rdy,
	input logic app_wdf_rdy
);

	strip_state_t state;
	strip_state_t state_nxt;

	// Direction of the strip in flight, high for a write
	logic wr_strip;

	// A beat is offered to the memory in this cycle
	logic issue;

	assign sif.state = state;

	// ============================================================
	// State register and next-state logic
	// ============================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (req) begin
					state_nxt = PRESET1;
				end
			end
			PRESET1: state_nxt = PRESET2;
			PRESET2: state_nxt = PRESET3;
			// Branch to the write or read path
			PRESET3: state_nxt = wr_strip ? WRITE_DATA1 : READ_DATA0;
			WRITE_DATA1: begin
				if (!sif.beats_left) begin
					state_nxt = WRITE_DATA2;
				end
			end
			WRITE_DATA2: state_nxt = DONE;
			READ_DATA0: begin
				if (!sif.beats_left) begin
					state_nxt = READ_DATA1;
				end
			end
			// Read latency varies, so wait until the buffer has every word
			READ_DATA1: begin
				if (sif.rd_all) begin
					state_nxt = DONE;
				end
			end
			DONE: state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	// ============================================================
	// Request capture and address stepping
	// ============================================================

	// The request fields are taken on the req edge, so they hold from PRESET1 on.
	// The address then moves one beat forward on each accept
	always_ff @(posedge clk) begin
		if (state == IDLE && req) begin
			wr_strip <= we;
			sif.burst_len <= len;
			app_addr <= adr;
		end else if (sif.beat_accept) begin
			app_addr <= app_addr + BEAT_BYTES;
		end
	end

	// ============================================================
	// Memory command port
	// ============================================================

	// Command and data stay put under back-pressure since nothing
	// here changes until the beat is accepted
	assign issue = ((state == WRITE_DATA1) || (state == READ_DATA0)) && sif.beats_left;
	assign app_en = issue;
	assign app_wdf_wren = issue && (state == WRITE_DATA1);

	// One word fills one beat, so every write word is also the last of its burst
	assign app_wdf_end = app_wdf_wren;
	assign app_cmd = wr_strip ? CMD_WRITE : CMD_READ;

	// A write beat needs the data FIFO ready in the same cycle as the command
	assign sif.beat_accept = app_en && app_rdy && (!app_wdf_wren || app_wdf_rdy);

	assign done = (state == DONE);

endmodule

/* hdl/req_burst_cnt.sv */
`timescale 1ns/1ps

// Counts the accepted beats of the strip in flight
module req_burst_cnt import strip_ctrl_pkg::*; (
	input logic clk,
	strip_if.cnt sif
);

	// Set while the counter tracks an active strip
	logic armed;

	// ============================================================
	// Beat counting
	// ============================================================

	// IDLE clears the count, so every strip starts from beat zero.
	// The FSM itself comes out of reset in IDLE, which clears this block too
	always_ff @(posedge clk) begin
		if (sif.state == IDLE) begin
			sif.burst_cnt <= '0;
			armed <= 1'b0;
		end else begin
			case (sif.state)
				// Armed one cycle before the first beat can be issued
				PRESET3: begin
					armed <= 1'b1;
				end
				// Both issue states count the same way
				WRITE_DATA1, READ_DATA0: begin
					if (sif.beat_accept && armed) begin
						// Step to the next beat while the strip is not finished
						if (sif.burst_cnt != sif.burst_len) begin
							sif.burst_cnt <= sif.burst_cnt + 6'd1;
						end else begin
							// The accept of the final beat ends the strip.
							// The count stays on the last index
							armed <= 1'b0;
						end
					end
				end
				default: begin
				end
			endcase
		end
	end

	// Beats remain exactly as long as the counter is armed
	assign sif.beats_left = armed;

endmodule

/* hdl/strip_if.sv */
`timescale 1ns/1ps

// Signals shared by the controller, the burst counter and the strip buffer
interface strip_if import strip_ctrl_pkg::*; ();

	// Current transfer state, owned by the controller
	strip_state_t state;

	// Length of the strip in flight, latched with the request
	burst_len_t burst_len;

	// High in every cycle where the memory takes a command (and its data word)
	logic beat_accept;

	// Index of the beat being issued
	burst_len_t burst_cnt;

	// Level that stays high while beats of the strip remain to be issued
	logic beats_left;

	// High once every word of a read strip has come back
	logic rd_all;

	modport ctrl (output state, output burst_len, output beat_accept,
		input burst_cnt, input beats_left, input rd_all);

	modport cnt (input state, input burst_len, input beat_accept,
		output burst_cnt, output beats_left);

	// The strip buffer reports when a read strip is complete
	modport buff (input state, input burst_len, input burst_cnt,
		input beat_accept, output rd_all);

endinterface

/* hdl/strip_ctrl_pkg.sv */
package strip_ctrl_pkg;

	// ============================================================
	// Memory port widths
	// ============================================================

	// Byte address on the memory application port
	typedef logic [27:0] app_addr_t;

	// One data word, which fills one beat on the memory port
	typedef logic [127:0] app_data_t;

	// Beats in a strip minus one, also used for beat counts and buffer indices
	typedef logic [5:0] burst_len_t;

	// Command code on app_cmd
	typedef logic [2:0] app_cmd_t;

	// Command encodings as the memory core defines them
	localparam app_cmd_t CMD_WRITE = 3'd0;
	localparam app_cmd_t CMD_READ = 3'd1;

	// Address step between two consecutive beats of a strip
	localparam app_addr_t BEAT_BYTES = 28'd16;

	// Words held by the strip buffer, one per possible beat
	localparam int STRIP_DEPTH = 64;

	// ============================================================
	// Transfer state machine
	// ============================================================

	// The write path goes through WRITE_DATA1 and WRITE_DATA2,
	// the read path through READ_DATA0 and READ_DATA1
	typedef enum logic [3:0] {
		IDLE,
		PRESET1,
		PRESET2,
		PRESET3,
		WRITE_DATA1,
		WRITE_DATA2,
		READ_DATA0,
		READ_DATA1,
		DONE
	} strip_state_t;

endpackage
